/* verilog/sensor_pkg.sv */
package sensor_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int COEFF_W   = 16;
    localparam int NUM_TAPS  = 32;
    localparam int NUM_BANKS = 4;
    localparam int TAP_W     = $clog2(NUM_TAPS);
    localparam int BANK_W    = $clog2(NUM_BANKS);
    localparam int ACC_W     = SAMPLE_W + COEFF_W + TAP_W;  // 37 bits hold 32 full products

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEFF_W-1:0]  coeff_t;
    typedef logic [TAP_W-1:0]           tap_t;
    typedef logic [BANK_W-1:0]          bank_t;

    typedef enum logic [1:0] {
        AXIS_NONE = 2'd0,
        AXIS_X    = 2'd1,
        AXIS_Y    = 2'd2,
        AXIS_Z    = 2'd3
    } axis_t;

    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        FILTER_START = 2'd1,
        FILTER_WAIT  = 2'd2,
        HOLD         = 2'd3
    } seq_state_t;

    // moving average defaults
    localparam coeff_t MA16_COEFF = 16'sh1000;
    localparam coeff_t MA32_COEFF = 16'sh0800;
    localparam int     MA16_TAPS  = 16;

    function automatic coeff_t default_coeff(input bank_t bank, input tap_t tap);
        coeff_t value;
        value = '0;
        case (bank)
            bank_t'(0): begin
                if (int'(tap) < MA16_TAPS) begin
                    value = MA16_COEFF;
                end
            end
            bank_t'(1): value = MA32_COEFF;
            default:    value = '0;  // banks 2 and 3 start empty
        endcase
        return value;
    endfunction

endpackage

/* verilog/sample_timer.sv */
`timescale 1ns/100ps

module sample_timer #(
    parameter int SAMPLE_PERIOD = 500000
) (
    input  logic sys_clk,
    input  logic rst,
    output logic tick
);
    localparam int CNT_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(SAMPLE_PERIOD - 1);

    logic [CNT_W-1:0] count;

    assign tick = (count == CNT_TOP);  // one cycle per period

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    a_tick_single: assert property (@(posedge sys_clk) disable iff (rst)
        (SAMPLE_PERIOD > 1) && tick |=> !tick);

endmodule

/* verilog/filter_sequencer.sv */
`timescale 1ns/100ps

module filter_sequencer (
    input  logic sys_clk,
    input  logic rst,
    input  logic tick,
    input  logic x_busy,
    input  logic y_busy,
    input  logic z_busy,
    output logic run,
    output logic available,
    output logic data_interrupt
);
    import sensor_pkg::*;

    seq_state_t state;
    logic       available_d;  // last cycle's available
    logic       any_busy;

    assign any_busy = x_busy | y_busy | z_busy;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state     <= IDLE;
            run       <= 1'b0;
            available <= 1'b1;
        end else begin
            run <= 1'b0;
            case (state)
                IDLE: begin
                    if (tick) begin  // ticks elsewhere are dropped
                        state     <= FILTER_START;
                        run       <= 1'b1;
                        available <= 1'b0;
                    end
                end
                FILTER_START: begin
                    state <= FILTER_WAIT;  // engines raise busy on this edge
                end
                FILTER_WAIT: begin
                    if (!any_busy) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    state     <= IDLE;
                    available <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // interrupt one cycle after available rises
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            available_d    <= 1'b1;
            data_interrupt <= 1'b0;
        end else begin
            available_d    <= available;
            data_interrupt <= available & ~available_d;
        end
    end

    a_run_drops_avail: assert property (@(posedge sys_clk) disable iff (rst)
        run |-> $fell(available));

    a_irq_one_cycle: assert property (@(posedge sys_clk) disable iff (rst)
        data_interrupt |=> !data_interrupt);

    a_idle_not_busy: assert property (@(posedge sys_clk) disable iff (rst)
        (state == IDLE) |-> !any_busy);

endmodule

/* verilog/coeff_bank.sv */
`timescale 1ns/100ps

module coeff_bank #(
    parameter sensor_pkg::axis_t AXIS_ID = sensor_pkg::AXIS_X
) (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                update_en,
    input  sensor_pkg::axis_t   update_axis,
    input  sensor_pkg::bank_t   update_bank,
    input  sensor_pkg::tap_t    update_index,
    input  sensor_pkg::coeff_t  update_value,
    input  sensor_pkg::bank_t   bank_sel,
    input  sensor_pkg::tap_t    tap,
    output sensor_pkg::coeff_t  coeff
);
    import sensor_pkg::*;

    coeff_t mem [NUM_BANKS][NUM_TAPS];
    logic   wr_hit;

    assign wr_hit = update_en && (update_axis == AXIS_ID);  // only this axis

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int t = 0; t < NUM_TAPS; t++) begin
                    mem[b][t] <= default_coeff(bank_t'(b), tap_t'(t));
                end
            end
        end else if (wr_hit) begin
            mem[update_bank][update_index] <= update_value;
        end
    end

    // same-cycle read for the mac engine
    assign coeff = mem[bank_sel][tap];

    a_axis_id_valid: assert property (@(posedge sys_clk)
        AXIS_ID != AXIS_NONE);

endmodule

/* verilog/fir_mac.sv */
`timescale 1ns/100ps

module fir_mac #(
    parameter int FRAC_BITS = 16
) (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                run,
    input  sensor_pkg::sample_t sample_in,
    input  sensor_pkg::coeff_t  coeff,
    output sensor_pkg::tap_t    tap,
    output logic                busy,
    output sensor_pkg::sample_t filter_data
);
    import sensor_pkg::*;

    sample_t                 delay [NUM_TAPS];  // entry 0 is newest
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] product;
    logic signed [ACC_W-1:0] acc_next;
    logic signed [ACC_W-1:0] acc_scaled;
    logic                    last_tap;

    assign product    = ACC_W'(coeff) * ACC_W'(delay[tap]);
    assign acc_next   = acc + product;
    assign acc_scaled = acc_next >>> FRAC_BITS;  // arithmetic shift keeps sign
    assign last_tap   = (tap == tap_t'(NUM_TAPS - 1));

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            busy        <= 1'b0;
            tap         <= '0;
            filter_data <= '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                delay[i] <= '0;
            end
        end else if (run) begin
            busy     <= 1'b1;
            tap      <= '0;
            delay[0] <= sample_in;
            for (int i = 1; i < NUM_TAPS; i++) begin
                delay[i] <= delay[i-1];
            end
        end else if (busy) begin
            tap <= tap + 1'b1;
            if (last_tap) begin  // final product folded in here
                busy        <= 1'b0;
                filter_data <= acc_scaled[SAMPLE_W-1:0];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (run) begin
            acc <= '0;
        end else if (busy) begin
            acc <= acc_next;
        end
    end

    a_no_run_when_busy: assert property (@(posedge sys_clk) disable iff (rst)
        run |-> !busy);

endmodule

/* verilog/accel_filter_top.sv */
`timescale 1ns/100ps

module accel_filter_top #(
    parameter int SAMPLE_PERIOD = 500000,
    parameter int FRAC_BITS     = 16
) (
    input  logic                sys_clk,
    input  logic                rst,
    input  sensor_pkg::sample_t x_sample,
    input  sensor_pkg::sample_t y_sample,
    input  sensor_pkg::sample_t z_sample,
    input  sensor_pkg::bank_t   x_bank,
    input  sensor_pkg::bank_t   y_bank,
    input  sensor_pkg::bank_t   z_bank,
    input  logic                update_en,
    input  sensor_pkg::axis_t   update_axis,
    input  sensor_pkg::bank_t   update_bank,
    input  sensor_pkg::tap_t    update_index,
    input  sensor_pkg::coeff_t  update_value,
    output sensor_pkg::sample_t x_data,
    output sensor_pkg::sample_t y_data,
    output sensor_pkg::sample_t z_data,
    output logic                available,
    output logic                data_interrupt
);
    import sensor_pkg::*;

    logic   tick;
    logic   run;
    logic   x_busy;
    logic   y_busy;
    logic   z_busy;
    tap_t   x_tap;
    tap_t   y_tap;
    tap_t   z_tap;
    coeff_t x_coeff;
    coeff_t y_coeff;
    coeff_t z_coeff;

    sample_timer #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) i_sample_timer (
        .sys_clk (sys_clk),
        .rst     (rst),
        .tick    (tick)
    );

    filter_sequencer i_filter_sequencer (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .tick           (tick),
        .x_busy         (x_busy),
        .y_busy         (y_busy),
        .z_busy         (z_busy),
        .run            (run),
        .available      (available),
        .data_interrupt (data_interrupt)
    );

    coeff_bank #(.AXIS_ID(AXIS_X)) i_coeff_bank_x (
        .sys_clk (sys_clk), .rst (rst),
        .update_en (update_en), .update_axis (update_axis), .update_bank (update_bank),
        .update_index (update_index), .update_value (update_value),
        .bank_sel (x_bank), .tap (x_tap), .coeff (x_coeff)
    );

    coeff_bank #(.AXIS_ID(AXIS_Y)) i_coeff_bank_y (
        .sys_clk (sys_clk), .rst (rst),
        .update_en (update_en), .update_axis (update_axis), .update_bank (update_bank),
        .update_index (update_index), .update_value (update_value),
        .bank_sel (y_bank), .tap (y_tap), .coeff (y_coeff)
    );

    coeff_bank #(.AXIS_ID(AXIS_Z)) i_coeff_bank_z (
        .sys_clk (sys_clk), .rst (rst),
        .update_en (update_en), .update_axis (update_axis), .update_bank (update_bank),
        .update_index (update_index), .update_value (update_value),
        .bank_sel (z_bank), .tap (z_tap), .coeff (z_coeff)
    );

    fir_mac #(.FRAC_BITS(FRAC_BITS)) i_fir_mac_x (
        .sys_clk (sys_clk), .rst (rst), .run (run),
        .sample_in (x_sample), .coeff (x_coeff), .tap (x_tap),
        .busy (x_busy), .filter_data (x_data)
    );

    fir_mac #(.FRAC_BITS(FRAC_BITS)) i_fir_mac_y (
        .sys_clk (sys_clk), .rst (rst), .run (run),
        .sample_in (y_sample), .coeff (y_coeff), .tap (y_tap),
        .busy (y_busy), .filter_data (y_data)
    );

    fir_mac #(.FRAC_BITS(FRAC_BITS)) i_fir_mac_z (
        .sys_clk (sys_clk), .rst (rst), .run (run),
        .sample_in (z_sample), .coeff (z_coeff), .tap (z_tap),
        .busy (z_busy), .filter_data (z_data)
    );

endmodule

/* include/filter_model.svh */
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

localparam int MODEL_AXES  = 3;  // 0 x, 1 y, 2 z
localparam int MODEL_BANKS = 4;
localparam int MODEL_TAPS  = 32;
localparam int MODEL_FRAC  = 16;

logic signed [15:0] model_hist [MODEL_AXES][MODEL_TAPS];  // index 0 newest
logic signed [15:0] model_coeff [MODEL_AXES][MODEL_BANKS][MODEL_TAPS];

function automatic logic signed [15:0] reset_coeff(input int bank, input int tap);
    if (bank == 0) begin
        return (tap < 16) ? 16'sh1000 : 16'sh0000;
    end
    if (bank == 1) begin
        return 16'sh0800;
    end
    return 16'sh0000;
endfunction

task automatic init_model();
    for (int a = 0; a < MODEL_AXES; a++) begin
        for (int t = 0; t < MODEL_TAPS; t++) begin
            model_hist[a][t] = '0;
            for (int b = 0; b < MODEL_BANKS; b++) begin
                model_coeff[a][b][t] = reset_coeff(b, t);
            end
        end
    end
endtask

// one call per filtering with the x, y and z samples
task automatic push_samples(input logic signed [15:0] x, input logic signed [15:0] y,
                            input logic signed [15:0] z);
    for (int a = 0; a < MODEL_AXES; a++) begin
        for (int i = MODEL_TAPS - 1; i > 0; i--) begin
            model_hist[a][i] = model_hist[a][i-1];
        end
    end
    model_hist[0][0] = x;
    model_hist[1][0] = y;
    model_hist[2][0] = z;
endtask

task automatic record_write(input logic [1:0] axis, input logic [1:0] bank,
                            input logic [4:0] index, input logic [15:0] value);
    if (axis != 2'd0) begin  // axis none writes nothing
        model_coeff[int'(axis) - 1][bank][index] = value;
    end
endtask

function automatic logic [15:0] expected_output(input int axis, input logic [1:0] bank);
    longint acc;
    longint scaled;
    acc = 0;
    for (int i = 0; i < MODEL_TAPS; i++) begin
        acc += longint'(model_coeff[axis][bank][i]) * longint'(model_hist[axis][i]);
    end
    scaled = acc >>> MODEL_FRAC;
    return scaled[15:0];
endfunction

`endif

/* verif/accel_filter_tb.sv */
`timescale 1ns/100ps

module accel_filter_tb;
    import sensor_pkg::*;

    localparam int          PERIOD      = 64;  // cycles between ticks
    localparam int          CLK_NS      = 20;
    localparam int          NUM_PERIODS = 68;  // 16 + 32 + 12 + 8 filterings
    localparam int          WATCHDOG_NS = (NUM_PERIODS + 10) * PERIOD * CLK_NS * 2;
    localparam int unsigned RAND_SEED   = 32'h85e29649;

    logic    sys_clk = 1'b0;
    logic    rst;
    sample_t x_sample;
    sample_t y_sample;
    sample_t z_sample;
    bank_t   x_bank;
    bank_t   y_bank;
    bank_t   z_bank;
    logic    update_en;
    axis_t   update_axis;
    bank_t   update_bank;
    tap_t    update_index;
    coeff_t  update_value;
    sample_t x_data;
    sample_t y_data;
    sample_t z_data;
    logic    available;
    logic    data_interrupt;

    int      errors    = 0;
    sample_t exp_x     = '0;
    sample_t exp_y     = '0;
    sample_t exp_z     = '0;
    logic    expect_dc = 1'b0;  // history full of one constant
    logic    avail_n   = 1'b1;  // available seen at the last falling edge
    int      since_fall = 0;
    int      last_gap  = 0;
    int      falls     = 0;
    int      low_count = 0;

    `include "filter_model.svh"

    accel_filter_top #(.SAMPLE_PERIOD(PERIOD)) i_accel_filter_top (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .x_sample       (x_sample),
        .y_sample       (y_sample),
        .z_sample       (z_sample),
        .x_bank         (x_bank),
        .y_bank         (y_bank),
        .z_bank         (z_bank),
        .update_en      (update_en),
        .update_axis    (update_axis),
        .update_bank    (update_bank),
        .update_index   (update_index),
        .update_value   (update_value),
        .x_data         (x_data),
        .y_data         (y_data),
        .z_data         (z_data),
        .available      (available),
        .data_interrupt (data_interrupt)
    );

    always #(CLK_NS / 2) sys_clk = ~sys_clk;

    // spacing of available falls and length of the low phase
    always @(negedge sys_clk) begin
        avail_n <= available;
        if (avail_n && !available) begin
            last_gap   <= since_fall + 1;
            since_fall <= 0;
            falls      <= falls + 1;
        end else begin
            since_fall <= since_fall + 1;
        end
        low_count <= available ? 0 : low_count + 1;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic write_coeff(input axis_t axis, input bank_t bank, input tap_t index,
                               input coeff_t value);
        update_en    = 1'b1;
        update_axis  = axis;
        update_bank  = bank;
        update_index = index;
        update_value = value;
        record_write(axis, bank, index, value);
        @(negedge sys_clk);
        update_en = 1'b0;
    endtask

    // apply one sample set, then wait out its filtering
    task automatic next_period(input sample_t xs, input sample_t ys, input sample_t zs);
        x_sample = xs;
        y_sample = ys;
        z_sample = zs;
        push_samples(xs, ys, zs);
        exp_x = sample_t'(expected_output(0, x_bank));
        exp_y = sample_t'(expected_output(1, y_bank));
        exp_z = sample_t'(expected_output(2, z_bank));
        do begin
            @(negedge sys_clk);
        end while (!data_interrupt);
        @(negedge sys_clk);  // checks at the interrupt use the old inputs
    endtask

    a_reset_flags: assert property (@(posedge sys_clk)
        $fell(rst) |-> available && !data_interrupt)
        else report_error("available or data_interrupt not at reset value after reset");

    a_reset_data: assert property (@(posedge sys_clk)
        $fell(rst) |-> x_data == '0 && y_data == '0 && z_data == '0)
        else report_error($sformatf("mismatch x_data %h y_data %h z_data %h expected 0000",
                                    x_data, y_data, z_data));

    a_irq_follows_rise: assert property (@(posedge sys_clk) disable iff (rst)
        $rose(available) |=> data_interrupt)
        else report_error("data_interrupt missing in the cycle after available rose");

    a_irq_placed: assert property (@(posedge sys_clk) disable iff (rst)
        data_interrupt |-> $past(available) && !$past(available, 2))
        else report_error("data_interrupt high outside the cycle after a rise of available");

    a_irq_single: assert property (@(posedge sys_clk) disable iff (rst)
        data_interrupt |=> !data_interrupt)
        else report_error("data_interrupt high for more than one cycle");

    a_rise_in_time: assert property (@(posedge sys_clk) disable iff (rst)
        !available |-> low_count < PERIOD - 1)
        else report_error("available fell and did not rise again within a sample period");

    a_fall_gap: assert property (@(posedge sys_clk) disable iff (rst)
        $fell(available) && falls >= 2 |-> last_gap == PERIOD)
        else report_error($sformatf("mismatch last_gap %h expected %h", last_gap, PERIOD));

    a_data_stable: assert property (@(posedge sys_clk) disable iff (rst)
        available |-> $stable(x_data) && $stable(y_data) && $stable(z_data))
        else report_error($sformatf(
            "mismatch x_data %h y_data %h z_data %h changed while available high",
            x_data, y_data, z_data));

    a_data_value: assert property (@(posedge sys_clk) disable iff (rst)
        data_interrupt |-> x_data == exp_x && y_data == exp_y && z_data == exp_z)
        else report_error($sformatf("mismatch x_data %h/%h y_data %h/%h z_data %h/%h got/exp",
                                    x_data, exp_x, y_data, exp_y, z_data, exp_z));

    a_data_dc: assert property (@(posedge sys_clk) disable iff (rst)
        data_interrupt && expect_dc |->
            x_data == x_sample && y_data == y_sample && z_data == z_sample)
        else report_error($sformatf("mismatch x_data %h/%h y_data %h/%h z_data %h/%h got/exp",
                                    x_data, x_sample, y_data, y_sample, z_data, z_sample));

    initial begin
        int unsigned seed_ret;
        sample_t     xs;
        sample_t     ys;
        sample_t     zs;
        seed_ret     = $urandom(RAND_SEED);
        rst          = 1'b1;
        x_sample     = '0;
        y_sample     = '0;
        z_sample     = '0;
        x_bank       = bank_t'(0);
        y_bank       = bank_t'(0);
        z_bank       = bank_t'(0);
        update_en    = 1'b0;
        update_axis  = AXIS_NONE;
        update_bank  = '0;
        update_index = '0;
        update_value = '0;
        init_model();
        repeat (10) @(negedge sys_clk);
        rst = 1'b0;

        xs = sample_t'($urandom);
        ys = sample_t'($urandom);
        zs = sample_t'($urandom);
        for (int n = 1; n <= 16; n++) begin  // 16-tap average fills after 16
            expect_dc = (n >= 16);
            next_period(xs, ys, zs);
        end

        x_bank = bank_t'(1);
        y_bank = bank_t'(1);
        z_bank = bank_t'(1);
        for (int n = 1; n <= 32; n++) begin  // bank 2 loaded while unused
            write_coeff(AXIS_X, bank_t'(2), tap_t'(n - 1), coeff_t'($urandom));
            write_coeff(AXIS_Y, bank_t'(2), tap_t'(n - 1), coeff_t'($urandom));
            write_coeff(AXIS_Z, bank_t'(2), tap_t'(n - 1), coeff_t'($urandom));
            expect_dc = (n >= 16);
            next_period(xs, ys, zs);
        end

        expect_dc = 1'b0;
        x_bank    = bank_t'(2);
        y_bank    = bank_t'(2);
        z_bank    = bank_t'(2);
        for (int n = 1; n <= 12; n++) begin
            next_period(sample_t'($urandom), sample_t'($urandom), sample_t'($urandom));
        end

        // x-only and axis-none writes into the bank in use
        for (int n = 1; n <= 8; n++) begin
            write_coeff(AXIS_X, bank_t'(2), tap_t'($urandom), coeff_t'($urandom));
            write_coeff(AXIS_X, bank_t'(2), tap_t'($urandom), coeff_t'($urandom));
            write_coeff(AXIS_NONE, bank_t'(2), tap_t'($urandom), coeff_t'($urandom));
            next_period(sample_t'($urandom), sample_t'($urandom), sample_t'($urandom));
        end

        repeat (2) @(negedge sys_clk);
        $display("errors counted: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all filterings finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
verilog/sensor_pkg.sv
verilog/sample_timer.sv
verilog/filter_sequencer.sv
verilog/coeff_bank.sv
verilog/fir_mac.sv
verilog/accel_filter_top.sv
verif/accel_filter_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module accel_filter_tb \
    -f all.f \
    -Mdir obj_dir -o accel_filter_sim

./obj_dir/accel_filter_sim 2>&1 | tee log.txt

if grep -qx "Test completed successfully" log.txt; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
